//--- files.f
mmu_pkg.sv
verilog/tlb_entry_store.sv
verilog/dmw_match.sv
verilog/tlb_lookup_stage.sv
verilog/translate_stage.sv
verilog/resp_queue.sv
verilog/mmu_top.sv
sim/mmu_tb.sv

//--- mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vpn2_t;
    typedef logic [9:0]  asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;
    typedef logic [5:0]  ps_t;

    // the only legal page sizes
    localparam ps_t PS_4K = 6'd12;
    localparam ps_t PS_2M = 6'd21;

    typedef enum logic [1:0] {
        MEM_LOAD  = 2'd0,
        MEM_STORE = 2'd1,
        MEM_FETCH = 2'd2
    } mem_type_t;

    typedef enum logic [2:0] {
        EXCP_NONE = 3'd0,
        EXCP_TLBR = 3'd1,
        EXCP_PIL  = 3'd2,
        EXCP_PIS  = 3'd3,
        EXCP_PIF  = 3'd4,
        EXCP_PPI  = 3'd5,
        EXCP_PME  = 3'd6
    } excp_t;

    typedef struct packed {
        pfn_t pfn;
        mat_t mat;
        plv_t plv;
        logic d;
        logic v;
    } tlb_page_t;

    typedef struct packed {
        logic      e;
        logic      g;
        vpn2_t     vpn2;
        asid_t     asid;
        ps_t       ps;
        tlb_page_t even;
        tlb_page_t odd;
    } tlb_entry_t;

    typedef struct packed {
        logic       plv0;
        logic       plv3;
        mat_t       mat;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_t;

    typedef struct packed {
        vaddr_t    vaddr;
        asid_t     asid;
        plv_t      plv;
        mem_type_t mem_type;
    } xlate_req_t;

    // stage one result
    typedef struct packed {
        xlate_req_t req;
        logic       tlb_hit;
        tlb_page_t  page;
        ps_t        ps;
        logic       dmw_hit;
        mat_t       dmw_mat;
        paddr_t     dmw_paddr;
        logic       da;
    } lookup_t;

    typedef struct packed {
        vaddr_t vaddr;
        paddr_t paddr;
        mat_t   mat;
        excp_t  excp;
    } xlate_resp_t;

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module mmu_tb -f files.f -o mmu_sim

out=$(./obj_dir/mmu_sim 2>&1) || true
echo "$out"

if grep -q "TESTS PASSED" <<< "$out"; then
    exit 0
else
    exit 1
fi

//--- sim/mmu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_tb;

    localparam int TLB_ENTRIES  = 16;
    localparam int QUEUE_DEPTH  = 4;
    localparam int RESP_CREDITS = 2;
    localparam int NUM_REQ      = 600;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid;
    mmu_pkg::xlate_req_t  req;
    logic                 req_credit;
    logic                 resp_valid;
    mmu_pkg::xlate_resp_t resp;
    logic                 resp_credit;
    logic                 da_mode;
    mmu_pkg::dmw_t        dmw0;
    mmu_pkg::dmw_t        dmw1;
    logic                 tlb_we;
    logic [3:0]           w_index;
    mmu_pkg::tlb_entry_t  w_entry;
    logic                 inv_valid;
    logic [2:0]           inv_op;
    mmu_pkg::asid_t       inv_asid;
    mmu_pkg::vaddr_t      inv_vaddr;

    // reference state
    mmu_pkg::tlb_entry_t  model_tlb [TLB_ENTRIES];
    mmu_pkg::xlate_resp_t exp_q [$];
    logic [31:0]          lfsr;
    int                   up_credits;
    int                   down_credits;
    int                   owed;
    int                   sent;
    int                   received;
    int                   credit_total;
    int                   cycles;

    mmu_top #(
        .TLB_ENTRIES  (TLB_ENTRIES),
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .RESP_CREDITS (RESP_CREDITS)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .req_credit  (req_credit),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .resp_credit (resp_credit),
        .da_mode     (da_mode),
        .dmw0        (dmw0),
        .dmw1        (dmw1),
        .tlb_we      (tlb_we),
        .w_index     (w_index),
        .w_entry     (w_entry),
        .inv_valid   (inv_valid),
        .inv_op      (inv_op),
        .inv_asid    (inv_asid),
        .inv_vaddr   (inv_vaddr)
    );

    always #20 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic mmu_pkg::tlb_page_t random_page();
        mmu_pkg::tlb_page_t p;
        p.pfn = 20'(rand_bits(20));
        p.mat = 2'(rand_bits(2));
        p.plv = 2'(rand_bits(2));
        p.d   = 1'(rand_bits(1));
        p.v   = rand_bits(2) != 0;
        return p;
    endfunction

    // top vpn2 bits carry the index, so no two entries can both hit
    function automatic mmu_pkg::tlb_entry_t random_entry(input logic [3:0] idx);
        mmu_pkg::tlb_entry_t ent;
        ent.e    = rand_bits(3) != 0;
        ent.g    = rand_bits(2) == 0;
        ent.vpn2 = {idx, 15'(rand_bits(15))};
        ent.asid = 10'(rand_bits(2));
        ent.ps   = (rand_bits(1) != 0) ? mmu_pkg::PS_2M : mmu_pkg::PS_4K;
        ent.even = random_page();
        ent.odd  = random_page();
        return ent;
    endfunction

    function automatic mmu_pkg::dmw_t random_window();
        mmu_pkg::dmw_t w;
        w.plv0 = rand_bits(2) != 0;
        w.plv3 = rand_bits(2) != 0;
        w.mat  = 2'(rand_bits(2));
        w.vseg = 3'(rand_bits(3));
        w.pseg = 3'(rand_bits(3));
        return w;
    endfunction

    function automatic logic window_hits(input mmu_pkg::dmw_t w, input mmu_pkg::xlate_req_t r);
        logic lvl_ok;
        lvl_ok = (r.plv == 2'd0 && w.plv0) || (r.plv == 2'd3 && w.plv3);
        return lvl_ok && (r.vaddr[31:29] == w.vseg);
    endfunction

    function automatic logic vpn_matches(input mmu_pkg::tlb_entry_t ent, input mmu_pkg::vaddr_t va);
        if (ent.ps == mmu_pkg::PS_2M) begin
            return ent.vpn2[18:9] == va[31:22];
        end
        return ent.vpn2 == va[31:13];
    endfunction

    // expected response from the model array as it stands before the edge
    function automatic mmu_pkg::xlate_resp_t model_xlate(input mmu_pkg::xlate_req_t r,
                                                         input logic da,
                                                         input mmu_pkg::dmw_t w0,
                                                         input mmu_pkg::dmw_t w1);
        mmu_pkg::xlate_resp_t x;
        mmu_pkg::tlb_entry_t  hit_ent;
        mmu_pkg::tlb_page_t   pg;
        logic                 found;
        logic                 big;
        x.vaddr = r.vaddr;
        x.paddr = '0;
        x.mat   = 2'd0;
        x.excp  = mmu_pkg::EXCP_NONE;
        hit_ent = '0;
        found   = 1'b0;
        if (da) begin
            x.paddr = r.vaddr;
            return x;
        end
        if (window_hits(w0, r)) begin
            x.paddr = {w0.pseg, r.vaddr[28:0]};
            x.mat   = w0.mat;
            return x;
        end
        if (window_hits(w1, r)) begin
            x.paddr = {w1.pseg, r.vaddr[28:0]};
            x.mat   = w1.mat;
            return x;
        end
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (model_tlb[i].e && (model_tlb[i].g || model_tlb[i].asid == r.asid) &&
                vpn_matches(model_tlb[i], r.vaddr)) begin
                found   = 1'b1;
                hit_ent = model_tlb[i];
            end
        end
        if (!found) begin
            x.excp = mmu_pkg::EXCP_TLBR;
            return x;
        end
        big = hit_ent.ps == mmu_pkg::PS_2M;
        pg  = (big ? r.vaddr[21] : r.vaddr[12]) ? hit_ent.odd : hit_ent.even;
        if (!pg.v) begin
            if (r.mem_type == mmu_pkg::MEM_STORE) begin
                x.excp = mmu_pkg::EXCP_PIS;
            end else if (r.mem_type == mmu_pkg::MEM_FETCH) begin
                x.excp = mmu_pkg::EXCP_PIF;
            end else begin
                x.excp = mmu_pkg::EXCP_PIL;
            end
        end else if (r.plv > pg.plv) begin
            x.excp = mmu_pkg::EXCP_PPI;
        end else if (r.mem_type == mmu_pkg::MEM_STORE && !pg.d) begin
            x.excp = mmu_pkg::EXCP_PME;
        end else begin
            x.paddr = big ? {pg.pfn[19:9], r.vaddr[20:0]} : {pg.pfn, r.vaddr[11:0]};
            x.mat   = pg.mat;
        end
        return x;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("FAILED at %0t: %s", $time, msg));
    endtask

    task automatic check_resp(input mmu_pkg::xlate_resp_t got, input mmu_pkg::xlate_resp_t exp);
        if (got !== exp) begin
            value_error($sformatf(
                "vaddr %h got paddr %h mat %0d excp %0d, expected vaddr %h paddr %h mat %0d excp %0d",
                got.vaddr, got.paddr, got.mat, got.excp,
                exp.vaddr, exp.paddr, exp.mat, exp.excp));
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            value_error($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    // writes and invalidates land at the coming edge and an invalidate beats a write
    task automatic update_model();
        logic asid_ok;
        if (inv_valid) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                asid_ok = !model_tlb[i].g && (model_tlb[i].asid == inv_asid);
                if (inv_op == 3'd0) begin
                    model_tlb[i].e = 1'b0;
                end else if (inv_op == 3'd4 && asid_ok) begin
                    model_tlb[i].e = 1'b0;
                end else if (inv_op == 3'd5 && asid_ok && vpn_matches(model_tlb[i], inv_vaddr)) begin
                    model_tlb[i].e = 1'b0;
                end
            end
        end else if (tlb_we) begin
            model_tlb[w_index] = w_entry;
        end
    endtask

    task automatic drive_inputs(input logic allow_req);
        logic [3:0]          t;
        logic [2:0]          k;
        logic [1:0]          mt;
        mmu_pkg::tlb_entry_t ent;
        mmu_pkg::xlate_req_t r;
        if (rand_bits(5) == 0) begin
            dmw0 = random_window();
            dmw1 = random_window();
            // shared segment exercises window priority
            if (rand_bits(1) != 0) begin
                dmw1.vseg = dmw0.vseg;
            end
        end
        da_mode   = rand_bits(4) == 0;
        req_valid = 1'b0;
        if (allow_req && up_credits > 0 && rand_bits(2) != 0) begin
            t       = 4'(rand_bits(4));
            ent     = model_tlb[t];
            r.vaddr = rand_bits(32);
            if (rand_bits(2) != 0) begin
                if (ent.ps == mmu_pkg::PS_2M) begin
                    r.vaddr[31:22] = ent.vpn2[18:9];
                end else begin
                    r.vaddr[31:13] = ent.vpn2;
                end
            end
            r.asid = (rand_bits(1) != 0) ? ent.asid : 10'(rand_bits(2));
            r.plv  = 2'(rand_bits(2));
            mt     = 2'(rand_bits(2));
            if (mt == 2'd3) begin
                mt = 2'd0;
            end
            r.mem_type = mmu_pkg::mem_type_t'(mt);
            req        = r;
            req_valid  = 1'b1;
            up_credits--;
            sent++;
            exp_q.push_back(model_xlate(r, da_mode, dmw0, dmw1));
        end
        resp_credit = (owed > 0) && (rand_bits(2) == 0);
        if (resp_credit) begin
            owed--;
        end
        tlb_we    = rand_bits(2) == 0;
        w_index   = 4'(rand_bits(4));
        w_entry   = random_entry(w_index);
        inv_valid = rand_bits(4) == 0;
        k         = 3'(rand_bits(3));
        inv_op    = (k == 3'd0) ? 3'd0 : (k[0] ? 3'd4 : 3'd5);
        inv_asid  = 10'(rand_bits(2));
        inv_vaddr = {model_tlb[4'(rand_bits(4))].vpn2, 13'(rand_bits(13))};
        update_model();
    endtask

    // outputs at mid-cycle show what happens at the coming edge
    task automatic sample_outputs();
        mmu_pkg::xlate_resp_t exp_r;
        if (req_credit) begin
            credit_total++;
            up_credits++;
            if (up_credits > QUEUE_DEPTH) begin
                value_error("req_credit returned a credit that was never spent");
            end
        end
        if (resp_valid) begin
            if (down_credits == 0) begin
                value_error("resp_valid asserted with no downstream credit");
            end
            if (exp_q.size() == 0) begin
                value_error("resp_valid asserted with no request outstanding");
            end
            exp_r = exp_q.pop_front();
            check_resp(resp, exp_r);
            down_credits--;
            received++;
            owed++;
        end
        if (resp_credit) begin
            down_credits++;
        end
    endtask

    task automatic run_cycle(input logic allow_req);
        @(posedge clk);
        #1;
        drive_inputs(allow_req);
        @(negedge clk);
        sample_outputs();
    endtask

    initial begin
        lfsr         = 32'd3;
        clk          = 1'b0;
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        resp_credit  = 1'b0;
        da_mode      = 1'b0;
        dmw0         = '0;
        dmw1         = '0;
        tlb_we       = 1'b0;
        w_index      = '0;
        w_entry      = '0;
        inv_valid    = 1'b0;
        inv_op       = '0;
        inv_asid     = '0;
        inv_vaddr    = '0;
        up_credits   = QUEUE_DEPTH;
        down_credits = RESP_CREDITS;
        owed         = 0;
        sent         = 0;
        received     = 0;
        credit_total = 0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            model_tlb[i] = '0;
        end

        repeat (4) begin
            @(posedge clk);
            #1;
            if (resp_valid || req_credit) begin
                value_error("resp_valid or req_credit high during reset");
            end
        end
        rst_n = 1'b1;

        // nothing may come out in the idle cycles
        repeat (3) begin
            run_cycle(1'b0);
        end

        cycles = 0;
        while (sent < NUM_REQ) begin
            run_cycle(1'b1);
            cycles++;
            if (cycles > 20000) begin
                abort_run("timeout: requests could not all be issued, credits stopped returning");
            end
        end

        cycles = 0;
        while (received < sent || owed != 0) begin
            run_cycle(1'b0);
            cycles++;
            if (cycles > 2000) begin
                abort_run("timeout: outstanding responses or credits did not drain");
            end
        end

        check_count("req_credit pulses", credit_total, received);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/dmw_match.sv
`timescale 1ns/1ps
`default_nettype none

module dmw_match (
    input  wire mmu_pkg::vaddr_t vaddr,
    input  wire mmu_pkg::plv_t   plv,
    input  wire mmu_pkg::dmw_t   dmw0,
    input  wire mmu_pkg::dmw_t   dmw1,
    output logic                 hit,
    output mmu_pkg::paddr_t      paddr,
    output mmu_pkg::mat_t        mat
);

    logic          hit0;
    logic          hit1;
    mmu_pkg::dmw_t win;

    function automatic logic win_hit(input mmu_pkg::dmw_t w, input mmu_pkg::vaddr_t va,
                                     input mmu_pkg::plv_t lvl);
        logic plv_ok;
        plv_ok = (lvl == 2'd0 && w.plv0) || (lvl == 2'd3 && w.plv3);
        return plv_ok && (va[31:29] == w.vseg);
    endfunction

    assign hit0 = win_hit(dmw0, vaddr, plv);
    assign hit1 = win_hit(dmw1, vaddr, plv);

    // window 0 first
    assign win   = hit0 ? dmw0 : dmw1;
    assign hit   = hit0 || hit1;
    assign paddr = {win.pseg, vaddr[28:0]};
    assign mat   = win.mat;

endmodule

`default_nettype wire

//--- verilog/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_top #(
    parameter int TLB_ENTRIES  = 16,
    parameter int QUEUE_DEPTH  = 4,
    parameter int RESP_CREDITS = 2
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           req_valid,
    input  wire mmu_pkg::xlate_req_t      req,
    output logic                          req_credit,
    output logic                          resp_valid,
    output mmu_pkg::xlate_resp_t          resp,
    input  wire                           resp_credit,
    input  wire                           da_mode,
    input  wire mmu_pkg::dmw_t            dmw0,
    input  wire mmu_pkg::dmw_t            dmw1,
    input  wire                           tlb_we,
    input  wire [$clog2(TLB_ENTRIES)-1:0] w_index,
    input  wire mmu_pkg::tlb_entry_t      w_entry,
    input  wire                           inv_valid,
    input  wire [2:0]                     inv_op,
    input  wire mmu_pkg::asid_t           inv_asid,
    input  wire mmu_pkg::vaddr_t          inv_vaddr
);

    mmu_pkg::tlb_entry_t  entries [TLB_ENTRIES];
    logic                 lk_valid;
    mmu_pkg::lookup_t     lk;
    logic                 xl_valid;
    mmu_pkg::xlate_resp_t xl;

    tlb_entry_store #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) store_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .we        (tlb_we),
        .w_index   (w_index),
        .w_entry   (w_entry),
        .inv_valid (inv_valid),
        .inv_op    (inv_op),
        .inv_asid  (inv_asid),
        .inv_vaddr (inv_vaddr),
        .entries   (entries)
    );

    tlb_lookup_stage #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) lookup_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .entries   (entries),
        .da_mode   (da_mode),
        .dmw0      (dmw0),
        .dmw1      (dmw1),
        .out_valid (lk_valid),
        .out       (lk)
    );

    translate_stage xlate_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (lk_valid),
        .in        (lk),
        .out_valid (xl_valid),
        .out       (xl)
    );

    resp_queue #(
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .RESP_CREDITS (RESP_CREDITS)
    ) queue_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (xl_valid),
        .in          (xl),
        .resp_credit (resp_credit),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .req_credit  (req_credit)
    );

endmodule

`default_nettype wire

//--- verilog/resp_queue.sv
`timescale 1ns/1ps
`default_nettype none

module resp_queue #(
    parameter int QUEUE_DEPTH  = 4,
    parameter int RESP_CREDITS = 2
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       in_valid,
    input  wire mmu_pkg::xlate_resp_t in,
    input  wire                       resp_credit,
    output logic                      resp_valid,
    output mmu_pkg::xlate_resp_t      resp,
    output logic                      req_credit
);

    localparam int PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W  = $clog2(QUEUE_DEPTH + 1);
    localparam int CRED_W = $clog2(RESP_CREDITS + 1);

    mmu_pkg::xlate_resp_t slots [QUEUE_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic [CRED_W-1:0]    credits;
    logic                 send;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // head goes out only with a downstream credit
    assign send       = (count != '0) && (credits != '0);
    assign resp_valid = send;
    assign resp       = slots[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credits    <= CRED_W'(RESP_CREDITS);
            req_credit <= 1'b0;
        end else begin
            req_credit <= send;
            if (in_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (send) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({in_valid, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // returned credit counts even in a send cycle
            case ({send, resp_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            slots[wr_ptr] <= in;
        end
    end

endmodule

`default_nettype wire

//--- verilog/tlb_entry_store.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_entry_store #(
    parameter int TLB_ENTRIES = 16
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          we,
    input  wire [$clog2(TLB_ENTRIES)-1:0] w_index,
    input  wire mmu_pkg::tlb_entry_t     w_entry,
    input  wire                          inv_valid,
    input  wire [2:0]                    inv_op,
    input  wire mmu_pkg::asid_t          inv_asid,
    input  wire mmu_pkg::vaddr_t         inv_vaddr,
    output mmu_pkg::tlb_entry_t          entries [TLB_ENTRIES]
);

    mmu_pkg::tlb_entry_t    slots [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] e_bits;
    logic [TLB_ENTRIES-1:0] clr;

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        logic asid_hit;
        logic vpn_hit;

        assign asid_hit = !slots[i].g && (slots[i].asid == inv_asid);
        // 2 MB pages compare on the upper vpn2 bits only
        assign vpn_hit = (slots[i].ps == mmu_pkg::PS_2M) ?
                         (slots[i].vpn2[18:9] == inv_vaddr[31:22]) :
                         (slots[i].vpn2 == inv_vaddr[31:13]);

        always_comb begin
            case (inv_op)
                3'd0:    clr[i] = 1'b1;
                3'd4:    clr[i] = asid_hit;
                3'd5:    clr[i] = asid_hit && vpn_hit;
                default: clr[i] = 1'b0;
            endcase
        end

        always_comb begin
            entries[i]   = slots[i];
            entries[i].e = e_bits[i];
        end
    end

    // invalidate takes precedence, a same-cycle write is dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_bits <= '0;
        end else if (inv_valid) begin
            e_bits <= e_bits & ~clr;
        end else if (we) begin
            e_bits[w_index] <= w_entry.e;
        end
    end

    always_ff @(posedge clk) begin
        if (we && !inv_valid) begin
            slots[w_index] <= w_entry;
        end
    end

endmodule

`default_nettype wire

//--- verilog/tlb_lookup_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup_stage #(
    parameter int TLB_ENTRIES = 16
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      req_valid,
    input  wire mmu_pkg::xlate_req_t req,
    input  wire mmu_pkg::tlb_entry_t entries [TLB_ENTRIES],
    input  wire                      da_mode,
    input  wire mmu_pkg::dmw_t       dmw0,
    input  wire mmu_pkg::dmw_t       dmw1,
    output logic                     out_valid,
    output mmu_pkg::lookup_t         out
);

    logic [TLB_ENTRIES-1:0] match;
    mmu_pkg::tlb_entry_t    sel;
    logic                   odd;
    logic                   dmw_hit;
    mmu_pkg::paddr_t        dmw_paddr;
    mmu_pkg::mat_t          dmw_mat;
    mmu_pkg::lookup_t       nxt;

    dmw_match dmw_i (
        .vaddr (req.vaddr),
        .plv   (req.plv),
        .dmw0  (dmw0),
        .dmw1  (dmw1),
        .hit   (dmw_hit),
        .paddr (dmw_paddr),
        .mat   (dmw_mat)
    );

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_match
        logic vpn_hit;

        assign vpn_hit = (entries[i].ps == mmu_pkg::PS_2M) ?
                         (entries[i].vpn2[18:9] == req.vaddr[31:22]) :
                         (entries[i].vpn2 == req.vaddr[31:13]);
        assign match[i] = entries[i].e && vpn_hit &&
                          (entries[i].g || entries[i].asid == req.asid);
    end

    // and-or mux, match is one-hot
    always_comb begin
        sel = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (match[i]) begin
                sel = mmu_pkg::tlb_entry_t'(sel | entries[i]);
            end
        end
    end

    assign odd = (sel.ps == mmu_pkg::PS_2M) ? req.vaddr[21] : req.vaddr[12];

    always_comb begin
        nxt.req       = req;
        nxt.tlb_hit   = |match;
        nxt.page      = odd ? sel.odd : sel.even;
        nxt.ps        = sel.ps;
        nxt.dmw_hit   = dmw_hit;
        nxt.dmw_mat   = dmw_mat;
        nxt.dmw_paddr = dmw_paddr;
        nxt.da        = da_mode;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            out <= nxt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/translate_stage.sv
`timescale 1ns/1ps
`default_nettype none

module translate_stage (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   in_valid,
    input  wire mmu_pkg::lookup_t in,
    output logic                  out_valid,
    output mmu_pkg::xlate_resp_t  out
);

    mmu_pkg::paddr_t      tlb_pa;
    mmu_pkg::excp_t       tlb_excp;
    mmu_pkg::xlate_resp_t nxt;

    assign tlb_pa = (in.ps == mmu_pkg::PS_2M) ?
                    {in.page.pfn[19:9], in.req.vaddr[20:0]} :
                    {in.page.pfn, in.req.vaddr[11:0]};

    // refill, invalid, privilege, modify
    always_comb begin
        if (!in.tlb_hit) begin
            tlb_excp = mmu_pkg::EXCP_TLBR;
        end else if (!in.page.v) begin
            case (in.req.mem_type)
                mmu_pkg::MEM_STORE: tlb_excp = mmu_pkg::EXCP_PIS;
                mmu_pkg::MEM_FETCH: tlb_excp = mmu_pkg::EXCP_PIF;
                default:            tlb_excp = mmu_pkg::EXCP_PIL;
            endcase
        end else if (in.req.plv > in.page.plv) begin
            tlb_excp = mmu_pkg::EXCP_PPI;
        end else if (in.req.mem_type == mmu_pkg::MEM_STORE && !in.page.d) begin
            tlb_excp = mmu_pkg::EXCP_PME;
        end else begin
            tlb_excp = mmu_pkg::EXCP_NONE;
        end
    end

    always_comb begin
        nxt.vaddr = in.req.vaddr;
        if (in.da) begin
            nxt.paddr = in.req.vaddr;
            nxt.mat   = 2'd0;
            nxt.excp  = mmu_pkg::EXCP_NONE;
        end else if (in.dmw_hit) begin
            nxt.paddr = in.dmw_paddr;
            nxt.mat   = in.dmw_mat;
            nxt.excp  = mmu_pkg::EXCP_NONE;
        end else if (tlb_excp != mmu_pkg::EXCP_NONE) begin
            nxt.paddr = '0;
            nxt.mat   = 2'd0;
            nxt.excp  = tlb_excp;
        end else begin
            nxt.paddr = tlb_pa;
            nxt.mat   = in.page.mat;
            nxt.excp  = mmu_pkg::EXCP_NONE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out <= nxt;
        end
    end

endmodule

`default_nettype wire
